//--- intc.f
+incdir+.
axil_pkg.sv
intc_pkg.sv
axil_if.sv
intc_cfg_if.sv
intr_detect.sv
intr_pending.sv
intc_regs.sv
intc_top.sv
tb_clkgen.sv
intc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile the interrupt controller testbench with Verilator and run it
# exit status follows the pass line in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module intc_tb -f intc.f -o intc_sim \
	&& ./obj_dir/intc_sim | tee /dev/stderr | grep -q "TEST PASSED" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- intc_tb.sv
/*
 * testbench for the interrupt controller
 * AXI4-Lite bus tasks with random ready delays
 * reference model of trigger, polarity, enable and pending state
 * six tests, per-test report lines and a closing summary
 */
`timescale 1ns/1ps
`include "intc_settings.svh"

module intc_tb;

	localparam int N              = `INTC_NUM_SRC;
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int BUS_WAIT       = 64;
	localparam int SETTLE         = 8;

	// read-only and unmapped offsets, the first two are ID and RAW
	localparam axil_pkg::addr_t BAD_ADDR [6] = '{8'h10, 8'h14, 8'h18, 8'h1C, 8'h02, 8'hF0};

	logic                    CLK;
	logic                    nRST;
	logic [N-1:0]            intr_src;
	logic                    irq;
	logic                    awvalid;
	logic                    awready;
	logic [`INTC_ADDR_W-1:0] awaddr;
	logic                    wvalid;
	logic                    wready;
	logic [`INTC_DATA_W-1:0] wdata;
	logic [`INTC_STRB_W-1:0] wstrb;
	logic                    bvalid;
	logic                    bready;
	logic [1:0]              bresp;
	logic                    arvalid;
	logic                    arready;
	logic [`INTC_ADDR_W-1:0] araddr;
	logic                    rvalid;
	logic                    rready;
	logic [`INTC_DATA_W-1:0] rdata;
	logic [1:0]              rresp;

	integer seed;
	int     errors;
	int     failing_tests;
	int     cycle_count;

	// reference model state
	logic [N-1:0] m_trig;
	logic [N-1:0] m_pol;
	logic [N-1:0] m_en;
	logic [N-1:0] m_pend;
	logic [N-1:0] m_act;	// active level seen at the last update
	logic [N-1:0] m_src;	// value driven on intr_src

	tb_clkgen u_clkgen (
		.CLK  (CLK),
		.nRST (nRST)
	);

	intc_top UUT (.*);

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic logic [31:0] rand_word();
		rand_word = $random(seed);
	endfunction

	// AXI byte-lane rule, one strobe bit per data byte
	function automatic logic [31:0] byte_merge(input logic [31:0] old,
			input logic [31:0] data, input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				res[8*b +: 8] = data[8*b +: 8];
		end
		return res;
	endfunction

	// valid in bit 31 and the lowest enabled pending index, else zero
	function automatic logic [31:0] expected_id(input logic [N-1:0] pend,
			input logic [N-1:0] en);
		logic [31:0] w;
		logic        found;
		w     = '0;
		found = 1'b0;
		for (int i = 0; i < N; i++) begin
			if (!found && pend[i] && en[i]) begin
				found = 1'b1;
				w     = 32'h8000_0000 | 32'(i);
			end
		end
		return w;
	endfunction

	// pending after things have settled
	// level bits follow the active level, edge bits latch inactive to active
	task automatic model_update();
		logic a;
		for (int i = 0; i < N; i++) begin
			a = m_pol[i] ? m_src[i] : ~m_src[i];
			if (!m_trig[i])
				m_pend[i] = a;
			else if (a && !m_act[i])
				m_pend[i] = 1'b1;
			m_act[i] = a;
		end
	endtask

	task automatic settle(input int cycles);
		repeat (cycles) @(posedge CLK);
	endtask

	task automatic drive_sources(input logic [N-1:0] value);
		@(posedge CLK);
		intr_src <= value;
		m_src = value;
		model_update();
		settle(SETTLE);
	endtask

	// ----------------------------------------
	// bus tasks
	// ----------------------------------------
	task automatic axi_write(input axil_pkg::addr_t addr, input logic [31:0] data,
			input logic [3:0] strb, input int max_delay, output logic [1:0] resp);
		int n;
		int delay;
		delay = int'(rand_word() % 32'(max_delay + 1));
		resp  = 'x;
		@(posedge CLK);
		awvalid <= 1'b1;
		awaddr  <= addr;
		wvalid  <= 1'b1;
		wdata   <= data;
		wstrb   <= strb;
		n = 0;
		do begin
			@(posedge CLK);
			n++;
		end while (!(awready && wready) && n < BUS_WAIT);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		if (!(awready && wready)) begin
			$display("write to 0x%02h was never accepted by the DUT", addr);
			errors++;
		end else begin
			n = 0;
			do begin
				@(posedge CLK);
				n++;
			end while (!bvalid && n < BUS_WAIT);
			if (!bvalid) begin
				$display("write response for 0x%02h never arrived from the DUT", addr);
				errors++;
			end else begin
				resp = bresp;
				// response must hold and the slave must refuse new writes
				for (int k = 0; k < delay; k++) begin
					@(posedge CLK);
					if (!bvalid || bresp !== resp || awready || wready) begin
						$display("write response to 0x%02h changed or a new write was taken at %0t",
							addr, $time);
						errors++;
					end
				end
				bready <= 1'b1;
				@(posedge CLK);
				bready <= 1'b0;
			end
		end
	endtask

	task automatic axi_read(input axil_pkg::addr_t addr, input int max_delay,
			output logic [31:0] data, output logic [1:0] resp);
		int n;
		int delay;
		delay = int'(rand_word() % 32'(max_delay + 1));
		data  = 'x;
		resp  = 'x;
		@(posedge CLK);
		arvalid <= 1'b1;
		araddr  <= addr;
		n = 0;
		do begin
			@(posedge CLK);
			n++;
		end while (!arready && n < BUS_WAIT);
		arvalid <= 1'b0;
		if (!arready) begin
			$display("read of 0x%02h was never accepted by the DUT", addr);
			errors++;
		end else begin
			n = 0;
			do begin
				@(posedge CLK);
				n++;
			end while (!rvalid && n < BUS_WAIT);
			if (!rvalid) begin
				$display("read data for 0x%02h never arrived from the DUT", addr);
				errors++;
			end else begin
				data = rdata;
				resp = rresp;
				for (int k = 0; k < delay; k++) begin
					@(posedge CLK);
					if (!rvalid || rdata !== data || rresp !== resp || arready) begin
						$display("read response to 0x%02h changed or a new read was taken at %0t",
							addr, $time);
						errors++;
					end
				end
				rready <= 1'b1;
				@(posedge CLK);
				rready <= 1'b0;
			end
		end
	endtask

	task automatic read_expect(input axil_pkg::addr_t addr, input logic [31:0] exp_data,
			input logic [1:0] exp_resp, input int max_delay, input string what);
		logic [31:0] d;
		logic [1:0]  r;
		axi_read(addr, max_delay, d, r);
		if (d !== exp_data || r !== exp_resp) begin
			$display("mismatch at %0t: %s read 0x%08h resp %0d, expected 0x%08h resp %0d",
				$time, what, d, r, exp_data, exp_resp);
			errors++;
		end
	endtask

	// register write that the model follows, then wait for the pipeline
	task automatic cfg_write(input axil_pkg::addr_t addr, input logic [31:0] data,
			input logic [3:0] strb);
		logic [1:0] resp;
		axi_write(addr, data, strb, 4, resp);
		if (resp !== axil_pkg::OKAY) begin
			$display("mismatch at %0t: write to 0x%02h gave resp %0d, expected OKAY",
				$time, addr, resp);
			errors++;
		end
		case (addr)
			intc_pkg::REG_TRIG:    m_trig = N'(byte_merge(32'(m_trig), data, strb));
			intc_pkg::REG_POL:     m_pol  = N'(byte_merge(32'(m_pol), data, strb));
			intc_pkg::REG_ENABLE:  m_en   = N'(byte_merge(32'(m_en), data, strb));
			intc_pkg::REG_PENDING: m_pend = m_pend & ~(m_trig & N'(byte_merge('0, data, strb)));
			default: ;
		endcase
		model_update();
		settle(SETTLE);
	endtask

	task automatic expect_regs(input int max_delay);
		read_expect(intc_pkg::REG_TRIG, 32'(m_trig), axil_pkg::OKAY, max_delay, "TRIG");
		read_expect(intc_pkg::REG_POL, 32'(m_pol), axil_pkg::OKAY, max_delay, "POL");
		read_expect(intc_pkg::REG_ENABLE, 32'(m_en), axil_pkg::OKAY, max_delay, "ENABLE");
	endtask

	task automatic check_irq();
		@(posedge CLK);
		if (irq !== |(m_pend & m_en)) begin
			$display("mismatch at %0t: irq is %b, expected %b", $time, irq, |(m_pend & m_en));
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int start);
		int errs;
		errs = errors - start;
		$display("test %-14s %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
		if (errs != 0)
			failing_tests++;
	endtask

	// ----------------------------------------
	// watchdog
	// ----------------------------------------
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge CLK);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	// ----------------------------------------
	// tests
	// ----------------------------------------
	initial begin : main
		logic [1:0]  resp;
		logic [31:0] w;
		logic [N-1:0] mask;
		int          start;
		seed          = 32'h61e7_1ae6;
		errors        = 0;
		failing_tests = 0;
		// all ones keeps active-low level sources quiet after reset
		intr_src = '1;
		awvalid  = 1'b0;
		awaddr   = '0;
		wvalid   = 1'b0;
		wdata    = '0;
		wstrb    = '0;
		bready   = 1'b0;
		arvalid  = 1'b0;
		araddr   = '0;
		rready   = 1'b0;
		m_trig   = '0;
		m_pol    = '0;
		m_en     = '0;
		m_pend   = '0;
		m_act    = '0;
		m_src    = '1;

		// reset values of handshakes, registers and irq
		start = errors;
		wait (nRST === 1'b1);
		@(posedge CLK);
		if (awready !== 1'b1 || wready !== 1'b1 || arready !== 1'b1) begin
			$display("mismatch at %0t: ready signals not high after reset", $time);
			errors++;
		end
		if (bvalid !== 1'b0 || rvalid !== 1'b0 || irq !== 1'b0) begin
			$display("mismatch at %0t: bvalid, rvalid or irq not low after reset", $time);
			errors++;
		end
		settle(SETTLE);
		expect_regs(2);
		read_expect(intc_pkg::REG_PENDING, '0, axil_pkg::OKAY, 2, "PENDING after reset");
		read_expect(intc_pkg::REG_ID, '0, axil_pkg::OKAY, 2, "ID after reset");
		read_expect(intc_pkg::REG_RAW, 32'(m_src), axil_pkg::OKAY, 2, "RAW after reset");
		check_irq();
		report_test("reset_state", start);

		// byte-strobe writes, read-only and unmapped offsets
		start = errors;
		for (int k = 0; k < 8; k++) begin
			cfg_write(intc_pkg::REG_TRIG, rand_word(), 4'(rand_word()));
			cfg_write(intc_pkg::REG_POL, rand_word(), 4'(rand_word()));
			cfg_write(intc_pkg::REG_ENABLE, rand_word(), 4'(rand_word()));
			expect_regs(4);
		end
		for (int k = 0; k < 6; k++) begin
			axi_write(BAD_ADDR[k], rand_word(), 4'hf, 4, resp);
			if (resp !== axil_pkg::SLVERR) begin
				$display("mismatch at %0t: write to 0x%02h gave resp %0d, expected SLVERR",
					$time, BAD_ADDR[k], resp);
				errors++;
			end
			if (k >= 2)
				read_expect(BAD_ADDR[k], '0, axil_pkg::SLVERR, 4, "unmapped read");
		end
		expect_regs(4);
		read_expect(intc_pkg::REG_PENDING, 32'(m_pend), axil_pkg::OKAY, 4, "PENDING");
		report_test("reg_access", start);

		// edge sources latch only on inactive to active
		start = errors;
		cfg_write(intc_pkg::REG_TRIG, rand_word() | 32'h1, 4'hf);
		cfg_write(intc_pkg::REG_POL, rand_word(), 4'hf);
		cfg_write(intc_pkg::REG_PENDING, 32'hffff_ffff, 4'hf);
		read_expect(intc_pkg::REG_PENDING, 32'(m_pend), axil_pkg::OKAY, 4, "PENDING cleared");
		for (int k = 0; k < 12; k++) begin
			mask = N'(rand_word());
			// pulse out and back, edge bits must stay set
			for (int p = 0; p < 2; p++) begin
				drive_sources(m_src ^ mask);
				read_expect(intc_pkg::REG_PENDING, 32'(m_pend), axil_pkg::OKAY, 4, "PENDING");
				read_expect(intc_pkg::REG_RAW, 32'(m_src), axil_pkg::OKAY, 4, "RAW");
			end
		end
		report_test("edge_detect", start);

		// level tracking, clear hits edge bits only
		start = errors;
		cfg_write(intc_pkg::REG_TRIG, rand_word() & ~32'h1, 4'hf);
		for (int k = 0; k < 10; k++) begin
			drive_sources(N'(rand_word()));
			read_expect(intc_pkg::REG_PENDING, 32'(m_pend), axil_pkg::OKAY, 4, "PENDING");
			cfg_write(intc_pkg::REG_PENDING, rand_word(), 4'hf);
			read_expect(intc_pkg::REG_PENDING, 32'(m_pend), axil_pkg::OKAY, 4, "PENDING clr");
		end
		report_test("level_clear", start);

		// enable masking, irq and lowest-index id
		start = errors;
		for (int k = 0; k < 16; k++) begin
			if (k % 4 == 0) begin
				cfg_write(intc_pkg::REG_TRIG, rand_word(), 4'hf);
				cfg_write(intc_pkg::REG_POL, rand_word(), 4'hf);
			end
			w = (k == 5) ? 32'h0 : rand_word();
			cfg_write(intc_pkg::REG_ENABLE, w, 4'hf);
			drive_sources(N'(rand_word()));
			check_irq();
			read_expect(intc_pkg::REG_ID, expected_id(m_pend, m_en), axil_pkg::OKAY, 4, "ID");
			read_expect(intc_pkg::REG_PENDING, 32'(m_pend), axil_pkg::OKAY, 4, "PENDING");
		end
		report_test("mask_id", start);

		// long ready delays, bus tasks check hold and refusal
		start = errors;
		for (int k = 0; k < 8; k++) begin
			w = rand_word();
			axi_write(intc_pkg::REG_ENABLE, w, 4'hf, 40, resp);
			m_en = N'(w);
			if (resp !== axil_pkg::OKAY) begin
				$display("mismatch at %0t: ENABLE write gave resp %0d", $time, resp);
				errors++;
			end
			read_expect(intc_pkg::REG_ENABLE, 32'(m_en), axil_pkg::OKAY, 40, "ENABLE");
			read_expect(intc_pkg::REG_ID, expected_id(m_pend, m_en), axil_pkg::OKAY, 40, "ID");
			axi_write(8'h20, w, 4'hf, 40, resp);
			if (resp !== axil_pkg::SLVERR) begin
				$display("mismatch at %0t: unmapped write gave resp %0d", $time, resp);
				errors++;
			end
			read_expect(8'h24, '0, axil_pkg::SLVERR, 40, "unmapped read");
		end
		report_test("back_pressure", start);

		$display("summary: 6 tests, %0d failing, %0d errors, %0d cycles",
			failing_tests, errors, cycle_count);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- tb_clkgen.sv
/*
 * testbench clock and reset source
 * free-running clock, active-low reset held for a fixed number of cycles
 */
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic CLK,
	output logic nRST
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD_NS / 2) CLK = ~CLK;
	end

	// release on a rising edge so every flop leaves reset together
	initial begin
		nRST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		nRST <= 1'b1;
	end

endmodule

//--- intc_top.sv
/*
 * interrupt controller top level
 * plain AXI4-Lite and interrupt pins, register block, detector, pending logic
 */
`timescale 1ns/1ps
`include "intc_settings.svh"

module intc_top (
	input  logic                     CLK,
	input  logic                     nRST,
	// interrupt lines and request
	input  logic [`INTC_NUM_SRC-1:0] intr_src,
	output logic                     irq,
	// AXI4-Lite write address
	input  logic                     awvalid,
	output logic                     awready,
	input  logic [`INTC_ADDR_W-1:0]  awaddr,
	// AXI4-Lite write data
	input  logic                     wvalid,
	output logic                     wready,
	input  logic [`INTC_DATA_W-1:0]  wdata,
	input  logic [`INTC_STRB_W-1:0]  wstrb,
	// AXI4-Lite write response
	output logic                     bvalid,
	input  logic                     bready,
	output logic [1:0]               bresp,
	// AXI4-Lite read address
	input  logic                     arvalid,
	output logic                     arready,
	input  logic [`INTC_ADDR_W-1:0]  araddr,
	// AXI4-Lite read data
	output logic                     rvalid,
	input  logic                     rready,
	output logic [`INTC_DATA_W-1:0]  rdata,
	output logic [1:0]               rresp
);

	axil_if     bus ();
	intc_cfg_if cfg ();

	logic [`INTC_NUM_SRC-1:0] evt;

	// ----------------------------------------
	// pins onto the bus bundle
	// ----------------------------------------
	assign bus.awvalid = awvalid;
	assign bus.awaddr  = awaddr;
	assign bus.wvalid  = wvalid;
	assign bus.wdata   = wdata;
	assign bus.wstrb   = wstrb;
	assign bus.bready  = bready;
	assign bus.arvalid = arvalid;
	assign bus.araddr  = araddr;
	assign bus.rready  = rready;

	assign awready = bus.awready;
	assign wready  = bus.wready;
	assign bvalid  = bus.bvalid;
	assign bresp   = bus.bresp;
	assign arready = bus.arready;
	assign rvalid  = bus.rvalid;
	assign rdata   = bus.rdata;
	assign rresp   = bus.rresp;

	// ----------------------------------------
	// blocks
	// ----------------------------------------
	intc_regs u_regs (
		.CLK  (CLK),
		.nRST (nRST),
		.bus  (bus),
		.cfg  (cfg)
	);

	intr_detect u_detect (
		.CLK      (CLK),
		.nRST     (nRST),
		.intr_src (intr_src),
		.cfg      (cfg),
		.evt      (evt)
	);

	intr_pending u_pending (
		.CLK  (CLK),
		.nRST (nRST),
		.evt  (evt),
		.cfg  (cfg),
		.irq  (irq)
	);

endmodule

//--- intc_regs.sv
/*
 * AXI4-Lite register slave of the interrupt controller
 * holds trigger, polarity and enable, issues the clear pulse
 * reads back configuration, pending, id and raw inputs
 */
`timescale 1ns/1ps
`include "intc_settings.svh"

module intc_regs (
	input  logic       CLK,
	input  logic       nRST,
	axil_if.slave      bus,
	intc_cfg_if.regs   cfg
);

	localparam int N  = `INTC_NUM_SRC;
	localparam int DW = `INTC_DATA_W;
	localparam int SW = `INTC_STRB_W;

	// configuration state
	logic [N-1:0] trig_q;
	logic [N-1:0] pol_q;
	logic [N-1:0] en_q;
	logic [N-1:0] clr_q;

	// handshakes and decode
	logic          wr_go;
	logic          wr_ok;
	logic          rd_go;
	logic          rd_ok;
	logic [DW-1:0] rd_data;

	// merge write data into a register, byte lanes by strobe
	function automatic logic [N-1:0] strb_merge(
		input logic [N-1:0]  old,
		input logic [DW-1:0] data,
		input logic [SW-1:0] strb
	);
		logic [N-1:0] res;
		res = old;
		for (int i = 0; i < N; i++) begin
			if (strb[i / 8])
				res[i] = data[i];
		end
		return res;
	endfunction

	assign cfg.trig   = trig_q;
	assign cfg.pol    = pol_q;
	assign cfg.enable = en_q;
	assign cfg.clr    = clr_q;

	// ----------------------------------------
	// write path
	// ----------------------------------------
	// address and data taken only as a pair, and never while a response waits
	assign bus.awready = ~bus.bvalid & (~bus.awvalid | bus.wvalid);
	assign bus.wready  = ~bus.bvalid & (~bus.wvalid | bus.awvalid);
	assign wr_go       = bus.awvalid & bus.wvalid & ~bus.bvalid;

	// writable offsets, id and raw are read only
	always_comb begin
		case (bus.awaddr)
			intc_pkg::REG_TRIG,
			intc_pkg::REG_POL,
			intc_pkg::REG_ENABLE,
			intc_pkg::REG_PENDING: wr_ok = 1'b1;
			default:               wr_ok = 1'b0;
		endcase
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			bus.bvalid <= 1'b0;
			trig_q     <= '0;
			pol_q      <= '0;
			en_q       <= '0;
			clr_q      <= '0;
		end else begin
			// clear pulse lasts a single cycle
			clr_q <= '0;
			if (wr_go) begin
				bus.bvalid <= 1'b1;
				case (bus.awaddr)
					intc_pkg::REG_TRIG:    trig_q <= strb_merge(trig_q, bus.wdata, bus.wstrb);
					intc_pkg::REG_POL:     pol_q  <= strb_merge(pol_q, bus.wdata, bus.wstrb);
					intc_pkg::REG_ENABLE:  en_q   <= strb_merge(en_q, bus.wdata, bus.wstrb);
					intc_pkg::REG_PENDING: clr_q  <= strb_merge('0, bus.wdata, bus.wstrb);
					default: ;
				endcase
			end else if (bus.bvalid && bus.bready) begin
				bus.bvalid <= 1'b0;
			end
		end
	end

	// response code only matters while bvalid is high
	always_ff @(posedge CLK) begin
		if (wr_go)
			bus.bresp <= wr_ok ? axil_pkg::OKAY : axil_pkg::SLVERR;
	end

	// ----------------------------------------
	// read path
	// ----------------------------------------
	assign bus.arready = ~bus.rvalid;
	assign rd_go       = bus.arvalid & ~bus.rvalid;

	// all registers zero-extended to the bus width
	always_comb begin
		rd_ok   = 1'b1;
		rd_data = '0;
		case (bus.araddr)
			intc_pkg::REG_TRIG:    rd_data = DW'(trig_q);
			intc_pkg::REG_POL:     rd_data = DW'(pol_q);
			intc_pkg::REG_ENABLE:  rd_data = DW'(en_q);
			intc_pkg::REG_PENDING: rd_data = DW'(cfg.pend);
			intc_pkg::REG_ID:      rd_data = DW'(cfg.id);
			intc_pkg::REG_RAW:     rd_data = DW'(cfg.raw);
			default:               rd_ok   = 1'b0;
		endcase
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			bus.rvalid <= 1'b0;
		end else if (rd_go) begin
			bus.rvalid <= 1'b1;
		end else if (bus.rready) begin
			bus.rvalid <= 1'b0;
		end
	end

	// data captured at the address handshake, held until accepted
	always_ff @(posedge CLK) begin
		if (rd_go) begin
			bus.rdata <= rd_data;
			bus.rresp <= rd_ok ? axil_pkg::OKAY : axil_pkg::SLVERR;
		end
	end

endmodule

//--- intr_pending.sv
/*
 * pending state, enable masking and id generation
 * edge bits latch until cleared, level bits mirror the event
 * lowest enabled pending index wins, irq registered alongside id
 */
`timescale 1ns/1ps
`include "intc_settings.svh"

module intr_pending (
	input  logic                     CLK,
	input  logic                     nRST,
	input  logic [`INTC_NUM_SRC-1:0] evt,
	intc_cfg_if.pending              cfg,
	output logic                     irq
);

	localparam int N = `INTC_NUM_SRC;

	// next value of each pending bit by trigger mode
	logic [N-1:0] edge_next;
	logic [N-1:0] level_next;

	// pending sources that software has enabled
	logic [N-1:0] masked;

	// combinational winner, registered below
	intc_pkg::id_word_t id_next;

	// ----------------------------------------
	// pending update
	// ----------------------------------------
	// a new edge in the same cycle as a clear keeps the bit set
	assign edge_next  = evt | (cfg.pend & ~cfg.clr);

	// level sources cannot be cleared, they follow the source
	assign level_next = evt;

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			cfg.pend <= '0;
		end else begin
			cfg.pend <= (cfg.trig & edge_next) | (~cfg.trig & level_next);
		end
	end

	// ----------------------------------------
	// masking and priority
	// ----------------------------------------
	assign masked = cfg.pend & cfg.enable;

	// scan from the top so the lowest set index is written last
	always_comb begin
		id_next = '0;
		for (int i = N - 1; i >= 0; i--) begin
			if (masked[i]) begin
				id_next.valid = 1'b1;
				id_next.idx   = intc_pkg::ID_IDX_W'(i);
			end
		end
	end

	// id and irq move together, one cycle behind pending
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			cfg.id <= '0;
			irq    <= 1'b0;
		end else begin
			cfg.id <= id_next;
			irq    <= id_next.valid;
		end
	end

endmodule

//--- intr_detect.sv
/*
 * per-source input synchronizer and event detection
 * polarity applied after sync, edge or level per source
 */
`timescale 1ns/1ps
`include "intc_settings.svh"

module intr_detect (
	input  logic                     CLK,
	input  logic                     nRST,
	input  logic [`INTC_NUM_SRC-1:0] intr_src,
	intc_cfg_if.detect               cfg,
	output logic [`INTC_NUM_SRC-1:0] evt
);

	localparam int N = `INTC_NUM_SRC;

	// first stage may go metastable, second is the stable copy
	logic [N-1:0] sync_meta;
	logic [N-1:0] sync_q;

	// active level after polarity, and its value one cycle ago
	logic [N-1:0] act;
	logic [N-1:0] act_prev;

	// ----------------------------------------
	// synchronizer
	// ----------------------------------------
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			sync_meta <= '0;
			sync_q    <= '0;
		end else begin
			sync_meta <= intr_src;
			sync_q    <= sync_meta;
		end
	end

	// software sees the line as it is on the pin
	assign cfg.raw = sync_q;

	// pol 1 keeps the line, pol 0 inverts it
	assign act = sync_q ^ ~cfg.pol;

	// ----------------------------------------
	// detect stage
	// ----------------------------------------
	// edge: pulse on inactive to active, level: follow the active level
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			act_prev <= '0;
			evt      <= '0;
		end else begin
			act_prev <= act;
			evt      <= (cfg.trig & act & ~act_prev) | (~cfg.trig & act);
		end
	end

endmodule

//--- intc_cfg_if.sv
/*
 * configuration and status bundle of the interrupt controller
 * links the register block to detection and pending logic
 */
`timescale 1ns/1ps
`include "intc_settings.svh"

interface intc_cfg_if;

	// from the register block
	logic [`INTC_NUM_SRC-1:0] trig;		// 1 = edge
	logic [`INTC_NUM_SRC-1:0] pol;		// 1 = active high
	logic [`INTC_NUM_SRC-1:0] enable;
	logic [`INTC_NUM_SRC-1:0] clr;		// one-cycle write-one-to-clear pulse

	// from the pending logic
	logic [`INTC_NUM_SRC-1:0] pend;
	intc_pkg::id_word_t       id;

	// from the detector, synchronized but not inverted
	logic [`INTC_NUM_SRC-1:0] raw;

	modport regs (
		output trig, pol, enable, clr,
		input  pend, id, raw
	);

	// detector needs mode and polarity only
	modport detect (
		input  trig, pol,
		output raw
	);

	modport pending (
		input  trig, enable, clr,
		output pend, id
	);

endinterface

//--- axil_if.sv
/*
 * AXI4-Lite interface bundle
 * five channels with master and slave modports
 */
`timescale 1ns/1ps
`include "intc_settings.svh"

interface axil_if;

	// write address channel
	logic                     awvalid;
	logic                     awready;
	axil_pkg::addr_t          awaddr;
	// write data channel
	logic                     wvalid;
	logic                     wready;
	logic [`INTC_DATA_W-1:0]  wdata;
	logic [`INTC_STRB_W-1:0]  wstrb;
	// write response channel
	logic                     bvalid;
	logic                     bready;
	axil_pkg::resp_t          bresp;
	// read address channel
	logic                     arvalid;
	logic                     arready;
	axil_pkg::addr_t          araddr;
	// read data channel
	logic                     rvalid;
	logic                     rready;
	logic [`INTC_DATA_W-1:0]  rdata;
	axil_pkg::resp_t          rresp;

	modport master (
		output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
		input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
	);

	modport slave (
		input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
		output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
	);

endinterface

//--- intc_pkg.sv
/*
 * controller-side types for the interrupt controller
 * register offset map and the id/status word layout
 */
`include "intc_settings.svh"

package intc_pkg;

	// ----------------------------------------
	// register map
	// ----------------------------------------
	typedef enum logic [`INTC_ADDR_W-1:0] {
		REG_TRIG    = `INTC_ADDR_W'('h00),	// 1 = edge, 0 = level
		REG_POL     = `INTC_ADDR_W'('h04),	// 1 = active high, 0 = active low
		REG_ENABLE  = `INTC_ADDR_W'('h08),	// per-source mask
		REG_PENDING = `INTC_ADDR_W'('h0C),	// write one clears edge bits
		REG_ID      = `INTC_ADDR_W'('h10),	// read only
		REG_RAW     = `INTC_ADDR_W'('h14)	// synchronized inputs, read only
	} reg_off_t;

	// ----------------------------------------
	// id word
	// ----------------------------------------
	// index field wide enough for 32 sources
	localparam int ID_IDX_W = 5;

	// valid in bit 31, winning source index in the low bits
	typedef struct packed {
		logic                               valid;
		logic [`INTC_DATA_W-2-ID_IDX_W:0]   rsvd;
		logic [ID_IDX_W-1:0]                idx;
	} id_word_t;

endpackage

//--- axil_pkg.sv
/*
 * bus-side types for the AXI4-Lite register port
 * response codes and the register address type
 */
`include "intc_settings.svh"

package axil_pkg;

	// ----------------------------------------
	// response codes
	// ----------------------------------------
	// only the two codes this slave ever returns
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_t;

	// ----------------------------------------
	// addressing
	// ----------------------------------------
	// byte address of a register, word aligned
	typedef logic [`INTC_ADDR_W-1:0] addr_t;

endpackage

//--- intc_settings.svh
/*
 * build-time sizing for the interrupt controller
 * source count, AXI4-Lite address, data and strobe widths
 */
`ifndef INTC_SETTINGS_SVH
`define INTC_SETTINGS_SVH

// number of external interrupt lines, 1 to 32
`define INTC_NUM_SRC 8

// AXI4-Lite address width, covers the register map
`define INTC_ADDR_W 8

// AXI4-Lite data width, one register per word
`define INTC_DATA_W 32

// one strobe bit per data byte
`define INTC_STRB_W (`INTC_DATA_W / 8)

`endif
